/* design/tl_pkg.sv */
/*
  Shared widths, opcodes and the device source layout of the burst fragmenter.
  Data path is fixed at 32 bits and host bursts are capped at 16 bytes.
  Only the A and D channel opcodes used here are listed.
*/
package tl_pkg;

  //////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////

  localparam int AddrWidth = 16;
  localparam int DataWidth = 32;
  localparam int DataBytes = DataWidth / 8;
  localparam int SizeWidth = 3;

  // Size field holds log2 of the byte count
  localparam int NonBurstSize = $clog2(DataBytes);
  localparam int HostMaxSize = 4;

  // Beats-left offset covers up to HostMaxSize worth of beats
  localparam int BurstLenWidth = HostMaxSize - NonBurstSize;

  localparam int HostSourceWidth = 2;
  localparam int DeviceSourceWidth = HostSourceWidth + BurstLenWidth;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    Get            = 3'd4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } tl_d_op_e;

  //////////////////////////////////////////////////
  // Device source field
  //////////////////////////////////////////////////

  // The device sees one flat source word. The fragmenter packs the host
  // source in the upper bits and the number of beats still to come in the
  // lower bits, so a response can be mapped back without extra state
  typedef union packed {
    logic [DeviceSourceWidth-1:0] raw;
    struct packed {
      logic [HostSourceWidth-1:0] source;
      logic [BurstLenWidth-1:0]   offset;
    } split;
  } dev_source_u;

endpackage

/* design/tl_channel.sv */
/*
  TileLink A and D channels only, with no corrupt or param fields.
  SourceWidth selects the host or the device source width.
*/
`timescale 1ns/1ps

interface tl_channel #(
  parameter int SourceWidth = tl_pkg::HostSourceWidth
);
  import tl_pkg::*;

  // Channel A
  logic                   a_valid;
  logic                   a_ready;
  tl_a_op_e               a_opcode;
  logic [SizeWidth-1:0]   a_size;
  logic [SourceWidth-1:0] a_source;
  logic [AddrWidth-1:0]   a_address;
  logic [DataBytes-1:0]   a_mask;
  logic [DataWidth-1:0]   a_data;

  // Channel D
  logic                   d_valid;
  logic                   d_ready;
  tl_d_op_e               d_opcode;
  logic [SizeWidth-1:0]   d_size;
  logic [SourceWidth-1:0] d_source;
  logic                   d_denied;
  logic [DataWidth-1:0]   d_data;

  // The requester side drives A and accepts D
  modport host (
    output a_valid, a_opcode, a_size, a_source, a_address, a_mask, a_data,
    input  a_ready,
    input  d_valid, d_opcode, d_size, d_source, d_denied, d_data,
    output d_ready
  );

  // The responder side accepts A and drives D
  modport device (
    input  a_valid, a_opcode, a_size, a_source, a_address, a_mask, a_data,
    output a_ready,
    output d_valid, d_opcode, d_size, d_source, d_denied, d_data,
    input  d_ready
  );

endinterface

/* design/tl_xact_fifo.sv */
/*
  Two-entry FIFO of transaction sizes. A push while full and a pop while
  empty are ignored. The head is visible the cycle after its push.
*/
`timescale 1ns/1ps

module tl_xact_fifo (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         push,
  input  logic [tl_pkg::SizeWidth-1:0] push_size,
  output logic                         can_push,
  input  logic                         pop,
  output logic                         peek_valid,
  output logic [tl_pkg::SizeWidth-1:0] peek_size
);
  import tl_pkg::*;

  logic [SizeWidth-1:0] entry_q [2];
  logic                 wr_ptr_q;
  logic                 rd_ptr_q;
  logic [1:0]           count_q;
  logic                 push_ok;
  logic                 pop_ok;

  assign can_push   = (count_q != 2'd2);
  assign peek_valid = (count_q != 2'd0);
  assign peek_size  = entry_q[rd_ptr_q];

  assign push_ok = push && can_push;
  assign pop_ok  = pop && peek_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop_ok) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Simultaneous push and pop leave the count alone
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 2'd1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      entry_q[wr_ptr_q] <= push_size;
    end
  end

endmodule

/* design/tl_adapter_tlul.sv */
/*
  Splits host bursts into single-beat device requests and regroups the replies.
  The device must answer in request order. Bursts are capped at HostMaxSize,
  burst addresses must be aligned, and Put beats all carry the burst address.
  Denied is passed through per beat and not merged across a burst.
*/
`timescale 1ns/1ps

module tl_adapter_tlul (
  input  logic      clk_i,
  input  logic      rst_ni,
  tl_channel.device host,
  tl_channel.host   device
);
  import tl_pkg::*;

  logic                       fifo_can_push;
  logic                       fifo_push;
  logic                       fifo_pop;
  logic                       fifo_peek_valid;
  logic [SizeWidth-1:0]       fifo_peek_size;

  enum logic [1:0] {
    ReqIdle,
    ReqGet,
    ReqPut
  } state_q, state_d;

  logic [HostSourceWidth-1:0] source_q, source_d;
  logic [AddrWidth-1:0]       address_q, address_d;
  logic [BurstLenWidth-1:0]   len_q, len_d;

  dev_source_u                a_src;
  dev_source_u                d_src;

  // Beats after the first one, zero for anything that fits in one beat
  function automatic logic [BurstLenWidth-1:0] burst_len(input logic [SizeWidth-1:0] size);
    logic [BurstLenWidth-1:0] len;
    len = '0;
    if (size > SizeWidth'(NonBurstSize)) begin
      len = BurstLenWidth'((1 << (size - SizeWidth'(NonBurstSize))) - 1);
    end
    return len;
  endfunction

  //////////////////////////////////////////////////
  // Transaction FIFO
  //////////////////////////////////////////////////

  // Holds the host size so that D beats can report it without having to
  // reconstruct it from the first offset of each response
  tl_xact_fifo i_xact_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push       (fifo_push),
    .push_size  (host.a_size),
    .can_push   (fifo_can_push),
    .pop        (fifo_pop),
    .peek_valid (fifo_peek_valid),
    .peek_size  (fifo_peek_size)
  );

  //////////////////////////////////////////////////
  // Channel A
  //////////////////////////////////////////////////

  assign device.a_source = a_src.raw;
  assign device.a_size   = SizeWidth'(NonBurstSize);

  always_comb begin
    host.a_ready     = 1'b0;
    device.a_valid   = 1'b0;
    device.a_opcode  = host.a_opcode;
    device.a_address = host.a_address;
    device.a_mask    = host.a_mask;
    device.a_data    = host.a_data;
    a_src.split.source = host.a_source;
    a_src.split.offset = burst_len(host.a_size);

    state_d   = state_q;
    source_d  = source_q;
    address_d = address_q;
    len_d     = len_q;
    fifo_push = 1'b0;

    unique case (state_q)
      ReqIdle: begin
        // First beat goes straight through once a FIFO slot is free
        host.a_ready   = device.a_ready && fifo_can_push;
        device.a_valid = host.a_valid && fifo_can_push;

        if (host.a_valid && device.a_ready && fifo_can_push) begin
          fifo_push = 1'b1;
          if (host.a_size > SizeWidth'(NonBurstSize)) begin
            source_d  = host.a_source;
            address_d = host.a_address + AddrWidth'(DataBytes);
            len_d     = burst_len(host.a_size) - BurstLenWidth'(1);
            state_d   = (host.a_opcode == Get) ? ReqGet : ReqPut;
          end
        end
      end

      ReqGet: begin
        // Remaining reads are generated here, the host is stalled
        device.a_valid     = 1'b1;
        device.a_opcode    = Get;
        device.a_address   = address_q;
        device.a_mask      = '1;
        device.a_data      = '0;
        a_src.split.source = source_q;
        a_src.split.offset = len_q;

        if (device.a_ready) begin
          address_d = address_q + AddrWidth'(DataBytes);
          len_d     = len_q - BurstLenWidth'(1);
          if (len_q == '0) begin
            state_d = ReqIdle;
          end
        end
      end

      ReqPut: begin
        host.a_ready       = device.a_ready;
        device.a_valid     = host.a_valid;
        device.a_address   = address_q;
        a_src.split.source = source_q;
        a_src.split.offset = len_q;

        if (host.a_valid && device.a_ready) begin
          address_d = address_q + AddrWidth'(DataBytes);
          len_d     = len_q - BurstLenWidth'(1);
          if (len_q == '0) begin
            state_d = ReqIdle;
          end
        end
      end

      default: begin
        state_d = ReqIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReqIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    source_q  <= source_d;
    address_q <= address_d;
    len_q     <= len_d;
  end

  //////////////////////////////////////////////////
  // Channel D
  //////////////////////////////////////////////////

  assign d_src.raw = device.d_source;

  assign host.d_opcode = device.d_opcode;
  assign host.d_source = d_src.split.source;
  assign host.d_size   = fifo_peek_size;
  assign host.d_denied = device.d_denied;
  assign host.d_data   = device.d_data;

  always_comb begin
    host.d_valid   = fifo_peek_valid && device.d_valid;
    device.d_ready = fifo_peek_valid && host.d_ready;

    // Intermediate write acks are swallowed here
    if (device.d_valid && device.d_opcode == AccessAck && d_src.split.offset != '0) begin
      host.d_valid   = 1'b0;
      device.d_ready = 1'b1;
    end

    // The beat with offset zero closes the transaction
    fifo_pop = fifo_peek_valid && device.d_valid && host.d_ready &&
               (d_src.split.offset == '0);
  end

endmodule

/* design/tl_ram_device.sv */
/*
  Single-beat TileLink memory of 256 words with one response register.
  Requests larger than one beat are not split and act on one word only.
  Addresses from 1024 up are denied, with no write and zero read data.
*/
`timescale 1ns/1ps

module tl_ram_device (
  input  logic      clk_i,
  input  logic      rst_ni,
  tl_channel.device bus
);
  import tl_pkg::*;

  localparam int MemWords = 256;
  localparam int IdxWidth = $clog2(MemWords);

  logic [DataWidth-1:0] mem_q [MemWords];

  logic                 rsp_valid_q;
  tl_d_op_e             rsp_opcode_q;
  logic [SizeWidth-1:0] rsp_size_q;
  logic [DeviceSourceWidth-1:0] rsp_source_q;
  logic                 rsp_denied_q;
  logic [DataWidth-1:0] rsp_data_q;

  logic                 accept;
  logic                 is_get;
  logic                 denied;
  logic [IdxWidth-1:0]  word_idx;

  // A new request fits whenever the response slot is free or draining
  assign bus.a_ready = !rsp_valid_q || bus.d_ready;
  assign accept      = bus.a_valid && bus.a_ready;

  assign is_get   = (bus.a_opcode == Get);
  assign denied   = (bus.a_address >= AddrWidth'(MemWords * DataBytes));
  assign word_idx = bus.a_address[NonBurstSize +: IdxWidth];

  assign bus.d_valid  = rsp_valid_q;
  assign bus.d_opcode = rsp_opcode_q;
  assign bus.d_size   = rsp_size_q;
  assign bus.d_source = rsp_source_q;
  assign bus.d_denied = rsp_denied_q;
  assign bus.d_data   = rsp_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Storage and response payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_opcode_q <= is_get ? AccessAckData : AccessAck;
      rsp_size_q   <= bus.a_size;
      rsp_source_q <= bus.a_source;
      rsp_denied_q <= denied;
      rsp_data_q   <= '0;

      if (is_get && !denied) begin
        rsp_data_q <= mem_q[word_idx];
      end

      // Both Put flavours honour the mask
      if (!is_get && !denied) begin
        for (int i = 0; i < DataBytes; i++) begin
          if (bus.a_mask[i]) begin
            mem_q[word_idx][8*i +: 8] <= bus.a_data[8*i +: 8];
          end
        end
      end
    end
  end

endmodule

/* design/tl_burst_top.sv */
/*
  Host burst port in front of the fragmenter and the on-chip memory.
  The host side speaks multi-beat TileLink, bursts of up to 16 bytes.
*/
`timescale 1ns/1ps

module tl_burst_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               a_valid,
  output logic                               a_ready,
  input  tl_pkg::tl_a_op_e                   a_opcode,
  input  logic [tl_pkg::SizeWidth-1:0]       a_size,
  input  logic [tl_pkg::HostSourceWidth-1:0] a_source,
  input  logic [tl_pkg::AddrWidth-1:0]       a_address,
  input  logic [tl_pkg::DataBytes-1:0]       a_mask,
  input  logic [tl_pkg::DataWidth-1:0]       a_data,
  output logic                               d_valid,
  input  logic                               d_ready,
  output tl_pkg::tl_d_op_e                   d_opcode,
  output logic [tl_pkg::SizeWidth-1:0]       d_size,
  output logic [tl_pkg::HostSourceWidth-1:0] d_source,
  output logic                               d_denied,
  output logic [tl_pkg::DataWidth-1:0]       d_data
);
  import tl_pkg::*;

  tl_channel #(.SourceWidth(HostSourceWidth))   host_ch ();
  tl_channel #(.SourceWidth(DeviceSourceWidth)) dev_ch ();

  // Host side port mapping
  assign host_ch.a_valid   = a_valid;
  assign host_ch.a_opcode  = a_opcode;
  assign host_ch.a_size    = a_size;
  assign host_ch.a_source  = a_source;
  assign host_ch.a_address = a_address;
  assign host_ch.a_mask    = a_mask;
  assign host_ch.a_data    = a_data;
  assign host_ch.d_ready   = d_ready;

  assign a_ready  = host_ch.a_ready;
  assign d_valid  = host_ch.d_valid;
  assign d_opcode = host_ch.d_opcode;
  assign d_size   = host_ch.d_size;
  assign d_source = host_ch.d_source;
  assign d_denied = host_ch.d_denied;
  assign d_data   = host_ch.d_data;

  tl_adapter_tlul i_adapter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .host   (host_ch),
    .device (dev_ch)
  );

  tl_ram_device i_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (dev_ch)
  );

endmodule

/* verif/tl_burst_tb.sv */
/*
  Table-driven testbench for the burst fragmenter and its memory.
  Only rows that were written before are read back, since the RAM starts as X.
  d_ready toggles from an LFSR, so responses arrive under random back-pressure.
*/
`timescale 1ns/1ps

module tl_burst_tb;
  import tl_pkg::*;

  localparam int NumRows = 16;
  localparam int ResetCycles = 8;

  typedef struct packed {
    tl_a_op_e                   opcode;
    logic [SizeWidth-1:0]       size;
    logic [HostSourceWidth-1:0] source;
    logic [AddrWidth-1:0]       address;
    logic [DataBytes-1:0]       mask;
    logic [DataWidth-1:0]       seed;
  } row_t;

  typedef struct packed {
    tl_d_op_e                   opcode;
    logic [SizeWidth-1:0]       size;
    logic [HostSourceWidth-1:0] source;
    logic                       denied;
    logic [DataWidth-1:0]       data;
  } rsp_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       a_valid;
  logic                       a_ready;
  tl_a_op_e                   a_opcode;
  logic [SizeWidth-1:0]       a_size;
  logic [HostSourceWidth-1:0] a_source;
  logic [AddrWidth-1:0]       a_address;
  logic [DataBytes-1:0]       a_mask;
  logic [DataWidth-1:0]       a_data;
  logic                       d_valid;
  logic                       d_ready;
  tl_d_op_e                   d_opcode;
  logic [SizeWidth-1:0]       d_size;
  logic [HostSourceWidth-1:0] d_source;
  logic                       d_denied;
  logic [DataWidth-1:0]       d_data;

  row_t        stim [NumRows];
  rsp_t        exp_q [$];
  rsp_t        exp_rsp;
  logic [7:0]  model_mem [1024];
  logic [31:0] lfsr;
  int          value_errors = 0;
  int          other_errors = 0;
  int          rsp_count = 0;
  int          predicted_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  tl_burst_top i_tl_burst_top (
    .clk_i, .rst_ni, .a_valid, .a_ready, .a_opcode, .a_size, .a_source, .a_address,
    .a_mask, .a_data, .d_valid, .d_ready, .d_opcode, .d_size, .d_source, .d_denied, .d_data
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Taps 32, 22, 2 and 1 give a maximal length sequence
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] read_model(input int addr);
    return {model_mem[addr+3], model_mem[addr+2], model_mem[addr+1], model_mem[addr]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %t %s: expected 0x%0h, got 0x%0h", $time, name, exp, got);
      value_errors++;
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d value errors, %0d other errors, %0d of %0d responses seen",
             value_errors, other_errors, rsp_count, predicted_count);
  endtask

  // Holds one host beat on channel A until it is taken
  task automatic send_beat(input row_t r, input logic [31:0] data);
    logic taken;
    a_valid   = 1'b1;
    a_opcode  = r.opcode;
    a_size    = r.size;
    a_source  = r.source;
    a_address = r.address;
    a_mask    = r.mask;
    a_data    = data;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = a_ready;
      @(posedge clk_i);
      #1;
    end
    a_valid = 1'b0;
  endtask

  // Updates the byte model, queues the expected replies, then drives the row
  task automatic run_row(input row_t r);
    int          beats;
    int          addr;
    logic        denied;
    logic [31:0] word;
    rsp_t        rsp;
    beats         = 1 << (int'(r.size) - NonBurstSize);
    denied        = (r.address >= 16'd1024);
    rsp.size      = r.size;
    rsp.source    = r.source;
    rsp.denied    = denied;
    if (r.opcode == Get) begin
      rsp.opcode = AccessAckData;
      for (int k = 0; k < beats; k++) begin
        addr     = int'(r.address) + 4 * k;
        rsp.data = denied ? 32'h0 : read_model(addr);
        exp_q.push_back(rsp);
        predicted_count++;
      end
      send_beat(r, 32'h0);
    end else begin
      for (int k = 0; k < beats; k++) begin
        addr = int'(r.address) + 4 * k;
        word = r.seed + 32'(k);
        for (int b = 0; b < DataBytes; b++) begin
          if (!denied && r.mask[b]) begin
            model_mem[addr+b] = word[8*b +: 8];
          end
        end
      end
      // A Put burst is answered by its last ack only
      rsp.opcode = AccessAck;
      rsp.data   = 32'h0;
      exp_q.push_back(rsp);
      predicted_count++;
      for (int k = 0; k < beats; k++) begin
        send_beat(r, r.seed + 32'(k));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int total_beats;
    $timeformat(-9, 0, " ns", 0);
    a_valid   = 1'b0;
    a_opcode  = PutFullData;
    a_size    = '0;
    a_source  = '0;
    a_address = '0;
    a_mask    = '0;
    a_data    = '0;
    rst_ni    = 1'b0;

    stim[0]  = '{PutFullData,    3'd2, 2'd0, 16'h0000, 4'hf, 32'h1122_3344};
    stim[1]  = '{Get,            3'd2, 2'd1, 16'h0000, 4'hf, 32'h0};
    stim[2]  = '{PutFullData,    3'd4, 2'd2, 16'h0010, 4'hf, 32'hA000_0000};
    stim[3]  = '{Get,            3'd4, 2'd3, 16'h0010, 4'hf, 32'h0};
    stim[4]  = '{PutPartialData, 3'd2, 2'd1, 16'h0014, 4'h5, 32'h5566_7788};
    stim[5]  = '{Get,            3'd2, 2'd0, 16'h0014, 4'hf, 32'h0};
    stim[6]  = '{PutFullData,    3'd3, 2'd3, 16'h0040, 4'hf, 32'hC0DE_0000};
    stim[7]  = '{Get,            3'd3, 2'd2, 16'h0040, 4'hf, 32'h0};
    stim[8]  = '{PutFullData,    3'd2, 2'd0, 16'h0100, 4'hf, 32'h0BAD_F00D};
    stim[9]  = '{PutPartialData, 3'd3, 2'd2, 16'h0040, 4'h9, 32'h99AA_BBCC};
    stim[10] = '{Get,            3'd3, 2'd1, 16'h0040, 4'hf, 32'h0};
    stim[11] = '{Get,            3'd2, 2'd3, 16'h0100, 4'hf, 32'h0};
    // 0x0410 aliases word 0x0010 in the RAM, so a stray write would show up
    stim[12] = '{PutFullData,    3'd4, 2'd1, 16'h0410, 4'hf, 32'hDEAD_0000};
    stim[13] = '{Get,            3'd4, 2'd2, 16'h0410, 4'hf, 32'h0};
    stim[14] = '{Get,            3'd4, 2'd0, 16'h0010, 4'hf, 32'h0};
    stim[15] = '{Get,            3'd2, 2'd3, 16'h0000, 4'hf, 32'h0};

    total_beats = 0;
    for (int i = 0; i < NumRows; i++) begin
      total_beats += 1 << (int'(stim[i].size) - NonBurstSize);
    end
    cycle_limit = total_beats * 20 + ResetCycles;

    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int i = 0; i < NumRows; i++) begin
      run_row(stim[i]);
    end

    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    // A few idle cycles to catch responses nobody asked for
    repeat (10) @(posedge clk_i);

    assert (rsp_count == predicted_count) else begin
      $display("Response count is wrong: %0d seen, %0d predicted", rsp_count, predicted_count);
      other_errors++;
    end

    print_summary();
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // Back-pressure, checker and watchdog
  //////////////////////////////////////////////////

  initial begin
    d_ready = 1'b0;
    lfsr    = 32'hda3421bd;
    forever begin
      @(posedge clk_i);
      #1;
      lfsr    = next_lfsr(lfsr);
      d_ready = lfsr[0];
    end
  end

  // Sampled mid-cycle, a beat seen here transfers on the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni && d_valid && d_ready) begin
      rsp_count++;
      assert (exp_q.size() != 0) else begin
        $display("Unexpected response at %t with nothing outstanding", $time);
        other_errors++;
      end
      if (exp_q.size() != 0) begin
        exp_rsp = exp_q.pop_front();
        compare_value("d_opcode", 32'(d_opcode), 32'(exp_rsp.opcode));
        compare_value("d_size", 32'(d_size), 32'(exp_rsp.size));
        compare_value("d_source", 32'(d_source), 32'(exp_rsp.source));
        compare_value("d_denied", 32'(d_denied), 32'(exp_rsp.denied));
        if (exp_rsp.opcode == AccessAckData) begin
          compare_value("d_data", d_data, exp_rsp.data);
        end
      end
    end
  end

  initial begin
    while (cycle_count <= cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    other_errors++;
    print_summary();
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* project.f */
design/tl_pkg.sv
design/tl_channel.sv
design/tl_xact_fifo.sv
design/tl_adapter_tlul.sv
design/tl_ram_device.sv
design/tl_burst_top.sv
verif/tl_burst_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the burst fragmenter testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tl_burst_tb -f project.f \
  -o tl_burst_sim || exit 1
sim_out="$(./obj_dir/tl_burst_sim)"
echo "$sim_out"
grep -q "ALL CHECKS PASSED" <<< "$sim_out" && exit 0 || exit 1
